/* common/mem_geom_pkg.sv */
// Lane count, data width, lane mask and word types, SRAM read latency
`default_nettype none

package mem_geom_pkg;

    // Byte lanes per word
    // Byte, halfword and word accesses span one, two and four of them
    localparam int LANES = 4;

    // Width of one data word
    localparam int DATA_W = LANES * 8;

    // Write enable mask with one bit per byte lane
    typedef logic [LANES-1:0] lane_mask_t;

    // Data word on the SRAM, store and load paths
    typedef logic [DATA_W-1:0] word_t;

    // Cycles from the SRAM input registers to its read data.
    // Two register stages plus the registered array read.
    localparam int SRAM_LATENCY = 3;

endpackage : mem_geom_pkg

`default_nettype wire

/* common/access_pkg.sv */
// Access size enum and byte offset type
`default_nettype none

package access_pkg;

    // Size of a load or store
    // Encoding 2'b11 is unused and treated as illegal by the encoder
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } access_size_e;

    // Byte position inside a word from the low address bits
    typedef logic [1:0] byte_off_t;

endpackage : access_pkg

`default_nettype wire

/* design/lane_encoder.sv */
// Input side alignment check, byte lane mask, store data placement and load tag
`timescale 1ns/1ps
`default_nettype none

module lane_encoder #(
    parameter int ADDR_W = 8
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req,
    input  logic                      wr,
    input  access_pkg::access_size_e  size,
    input  logic                      sign_ext,
    input  logic [ADDR_W+1:0]         addr,
    input  mem_geom_pkg::word_t       wdata,
    output logic                      cs,
    output mem_geom_pkg::lane_mask_t  we,
    output logic [ADDR_W-1:0]         word_addr,
    output mem_geom_pkg::word_t       lane_din,
    output logic                      rd_issue,
    output access_pkg::byte_off_t     rd_off,
    output access_pkg::access_size_e  rd_size,
    output logic                      rd_sign,
    output logic                      err
);
    import mem_geom_pkg::*;
    import access_pkg::*;

    byte_off_t  off;
    lane_mask_t mask;
    logic       misalign;
    logic       accept;

    assign off    = addr[1:0];
    assign accept = req && !misalign;

    // Lane mask and alignment rule from size and offset
    always_comb begin
        misalign = 1'b0;
        mask     = '0;
        case (size)
            size_byte: mask = 4'b0001 << off;
            size_half: begin
                misalign = off[0];
                mask     = 4'b0011 << off;
            end
            size_word: begin
                misalign = (off != 2'd0);
                mask     = 4'b1111;
            end
            default: misalign = 1'b1;
        endcase
    end

    // Strobes to the SRAM and the load aligner
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cs       <= 1'b0;
            we       <= '0;
            rd_issue <= 1'b0;
            err      <= 1'b0;
        end else begin
            cs       <= accept;
            we       <= (accept && wr) ? mask : '0;
            rd_issue <= accept && !wr;
            err      <= req && misalign;
        end
    end

    // Request payload with the store value moved up into its lanes
    always_ff @(posedge clk) begin
        if (accept) begin
            word_addr <= addr[ADDR_W+1:2];
            lane_din  <= wdata << {off, 3'b000};
            rd_off    <= off;
            rd_size   <= size;
            rd_sign   <= sign_ext;
        end
    end

    // Each accepted store writes as many lanes as its size covers
    a_store_lanes: assert property (@(posedge clk) disable iff (!rst_n)
        (accept && wr) |=> ($countones(we) == (1 << $past(size))));

endmodule : lane_encoder

`default_nettype wire

/* sram_bank/sram_byte_enable.sv */
// Three-stage pipelined single-port SRAM with per-byte write enables
`timescale 1ns/1ps
`default_nettype none

module sram_byte_enable #(
    parameter int ADDR_W = 8
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cs,
    input  mem_geom_pkg::lane_mask_t  we,
    input  logic [ADDR_W-1:0]         addr,
    input  mem_geom_pkg::word_t       din,
    output mem_geom_pkg::word_t       dout
);
    import mem_geom_pkg::*;

    localparam int DEPTH = 1 << ADDR_W;

    // Stage 1
    logic [ADDR_W-1:0] addr_s1;
    lane_mask_t        we_s1;
    word_t             din_s1;
    logic              cs_s1;

    // Stage 2
    logic [ADDR_W-1:0] addr_s2;
    lane_mask_t        we_s2;
    word_t             din_s2;
    logic              cs_s2;

    // Stage 3 read register
    word_t             dout_s3;

    // Storage with one byte per lane entry
    logic [7:0]        mem [DEPTH][LANES];

    // Input registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_s1 <= '0;
            we_s1   <= '0;
            din_s1  <= '0;
            cs_s1   <= 1'b0;
        end else begin
            addr_s1 <= addr;
            we_s1   <= we;
            din_s1  <= din;
            cs_s1   <= cs;
        end
    end

    // Second stage carries the access on unchanged
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_s2 <= '0;
            we_s2   <= '0;
            din_s2  <= '0;
            cs_s2   <= 1'b0;
        end else begin
            addr_s2 <= addr_s1;
            we_s2   <= we_s1;
            din_s2  <= din_s1;
            cs_s2   <= cs_s1;
        end
    end

    // Per-lane write
    always_ff @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            if (cs_s2 && we_s2[i]) begin
                mem[addr_s2][i] <= din_s2[i*8 +: 8];
            end
        end
    end

    // Registered read on every cycle
    // Returns the word as it was before a write on the same edge.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout_s3 <= '0;
        end else begin
            for (int j = 0; j < LANES; j++) begin
                dout_s3[j*8 +: 8] <= mem[addr_s2][j];
            end
        end
    end

    assign dout = dout_s3;

    // Write lanes only move together with a chip select
    a_we_needs_cs: assert property (@(posedge clk) disable iff (!rst_n)
        (we_s2 != '0) |-> cs_s2);

endmodule : sram_byte_enable

`default_nettype wire

/* design/load_align.sv */
// Output side load tag delay line, lane extraction and zero or sign extension
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      rd_issue,
    input  access_pkg::byte_off_t     rd_off,
    input  access_pkg::access_size_e  rd_size,
    input  logic                      rd_sign,
    input  mem_geom_pkg::word_t       dout,
    output mem_geom_pkg::word_t       rdata,
    output logic                      rvalid
);
    import mem_geom_pkg::*;
    import access_pkg::*;

    localparam int LAST = SRAM_LATENCY - 1;

    // Tag delay line matched to the SRAM latency
    logic         tag_vld  [SRAM_LATENCY];
    byte_off_t    tag_off  [SRAM_LATENCY];
    access_size_e tag_size [SRAM_LATENCY];
    logic         tag_sign [SRAM_LATENCY];

    word_t        shifted;
    word_t        aligned;

    // Tag valid shift register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < SRAM_LATENCY; k++) begin
                tag_vld[k] <= 1'b0;
            end
        end else begin
            tag_vld[0] <= rd_issue;
            for (int k = 1; k < SRAM_LATENCY; k++) begin
                tag_vld[k] <= tag_vld[k-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        tag_off[0]  <= rd_off;
        tag_size[0] <= rd_size;
        tag_sign[0] <= rd_sign;
        for (int k = 1; k < SRAM_LATENCY; k++) begin
            tag_off[k]  <= tag_off[k-1];
            tag_size[k] <= tag_size[k-1];
            tag_sign[k] <= tag_sign[k-1];
        end
    end

    // Bring the addressed lane down to bit 0
    assign shifted = dout >> {tag_off[LAST], 3'b000};

    always_comb begin
        case (tag_size[LAST])
            size_byte: begin
                if (tag_sign[LAST]) begin
                    aligned = {{(DATA_W-8){shifted[7]}}, shifted[7:0]};
                end else begin
                    aligned = {{(DATA_W-8){1'b0}}, shifted[7:0]};
                end
            end
            size_half: begin
                if (tag_sign[LAST]) begin
                    aligned = {{(DATA_W-16){shifted[15]}}, shifted[15:0]};
                end else begin
                    aligned = {{(DATA_W-16){1'b0}}, shifted[15:0]};
                end
            end
            default: aligned = shifted;
        endcase
    end

    // Result register holds its value between loads
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata  <= '0;
            rvalid <= 1'b0;
        end else begin
            rvalid <= tag_vld[LAST];
            if (tag_vld[LAST]) begin
                rdata <= aligned;
            end
        end
    end

    // Only aligned loads leave the delay line
    a_tag_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        tag_vld[LAST] |-> ((tag_size[LAST] == size_byte)
            || (tag_size[LAST] == size_half && !tag_off[LAST][0])
            || (tag_size[LAST] == size_word && tag_off[LAST] == 2'd0)));

endmodule : load_align

`default_nettype wire

/* design/mem_subsys_top.sv */
// Data memory top level with lane encoder, byte-enable SRAM bank and load aligner
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top #(
    parameter int ADDR_W = 8
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req,
    input  logic                      wr,
    input  access_pkg::access_size_e  size,
    input  logic                      sign_ext,
    input  logic [ADDR_W+1:0]         addr,
    input  mem_geom_pkg::word_t       wdata,
    output mem_geom_pkg::word_t       rdata,
    output logic                      rvalid,
    output logic                      err
);
    import mem_geom_pkg::*;
    import access_pkg::*;

    // Encoder to SRAM
    logic              cs;
    lane_mask_t        we;
    logic [ADDR_W-1:0] word_addr;
    word_t             lane_din;

    // Encoder to aligner
    logic              rd_issue;
    byte_off_t         rd_off;
    access_size_e      rd_size;
    logic              rd_sign;

    // SRAM read word
    word_t             dout;

    lane_encoder #(
        .ADDR_W (ADDR_W)
    ) u_lane_encoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .wr        (wr),
        .size      (size),
        .sign_ext  (sign_ext),
        .addr      (addr),
        .wdata     (wdata),
        .cs        (cs),
        .we        (we),
        .word_addr (word_addr),
        .lane_din  (lane_din),
        .rd_issue  (rd_issue),
        .rd_off    (rd_off),
        .rd_size   (rd_size),
        .rd_sign   (rd_sign),
        .err       (err)
    );

    sram_byte_enable #(
        .ADDR_W (ADDR_W)
    ) u_sram (
        .clk   (clk),
        .rst_n (rst_n),
        .cs    (cs),
        .we    (we),
        .addr  (word_addr),
        .din   (lane_din),
        .dout  (dout)
    );

    load_align u_load_align (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_issue (rd_issue),
        .rd_off   (rd_off),
        .rd_size  (rd_size),
        .rd_sign  (rd_sign),
        .dout     (dout),
        .rdata    (rdata),
        .rvalid   (rvalid)
    );

endmodule : mem_subsys_top

`default_nettype wire

/* verification/tb_mem_subsys.sv */
// Self-checking testbench for mem_subsys_top with a byte-array model and random stimulus
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;
    import mem_geom_pkg::*;
    import access_pkg::*;

    logic         clk;
    logic         rst_n;
    logic         req;
    logic         wr;
    access_size_e size;
    logic         sign_ext;
    logic [9:0]   addr;
    word_t        wdata;
    word_t        rdata;
    logic         rvalid;
    logic         err;

    // Reference byte memory and outstanding responses
    logic [7:0]   model_mem [1024];
    word_t        exp_data [$];
    int           exp_cyc [$];
    int           err_cyc [$];

    int           seed = 22108;
    int           cyc = 0;
    int           n_checks = 0;
    int           n_errors = 0;
    int           n_tests = 0;
    int           n_failed = 0;
    int           mark = 0;

    mem_subsys_top #(
        .ADDR_W (8)
    ) dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .wr       (wr),
        .size     (size),
        .sign_ext (sign_ext),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .rvalid   (rvalid),
        .err      (err)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic check_word(input string what, input word_t got, input word_t exp);
        n_checks++;
        assert (got === exp) else begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            n_errors++;
        end
    endtask

    // Drive one request and update the model by the alignment and lane rules
    task automatic issue_request(input logic w, input access_size_e s, input logic sx,
                                 input logic [9:0] a, input word_t d);
        logic        ok;
        logic [15:0] hw;
        word_t       v;
        ok = (s == size_byte) || (s == size_half && !a[0]) ||
             (s == size_word && a[1:0] == 2'b00);
        req      = 1'b1;
        wr       = w;
        size     = s;
        sign_ext = sx;
        addr     = a;
        wdata    = d;
        if (!ok) begin
            err_cyc.push_back(cyc + 1);
        end else if (w) begin
            model_mem[a] = d[7:0];
            if (s != size_byte) begin
                model_mem[a + 10'd1] = d[15:8];
            end
            if (s == size_word) begin
                model_mem[a + 10'd2] = d[23:16];
                model_mem[a + 10'd3] = d[31:24];
            end
        end else begin
            hw = {model_mem[a + 10'd1], model_mem[a]};
            if (s == size_byte) begin
                v = sx ? {{24{hw[7]}}, hw[7:0]} : {24'h0, hw[7:0]};
            end else if (s == size_half) begin
                v = sx ? {{16{hw[15]}}, hw} : {16'h0, hw};
            end else begin
                v = {model_mem[a + 10'd3], model_mem[a + 10'd2], hw};
            end
            exp_data.push_back(v);
            exp_cyc.push_back(cyc + 5);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycle();
        req = 1'b0;
        @(posedge clk);
        #1;
    endtask

    // Let all outstanding loads and error pulses come back
    task automatic wait_drain();
        int t;
        t = 0;
        req = 1'b0;
        while ((exp_data.size() != 0 || err_cyc.size() != 0) && t < 50) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (t >= 50) begin
            $display("Timeout: responses still outstanding after 50 cycles at %0t", $time);
            n_errors++;
        end
    endtask

    task automatic end_test(input string name);
        n_tests++;
        if (n_errors == mark) begin
            $display("test %0d %s: ok", n_tests, name);
        end else begin
            $display("test %0d %s: %0d errors", n_tests, name, n_errors - mark);
            n_failed++;
        end
        mark = n_errors;
    endtask

    // Response monitor on the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (rvalid) begin
                assert (exp_data.size() != 0) else begin
                    $display("Unexpected rvalid with no load outstanding at %0t", $time);
                    n_errors++;
                end
                if (exp_data.size() != 0) begin
                    check_word("load data", rdata, exp_data.pop_front());
                    check_word("load return cycle", word_t'(cyc), word_t'(exp_cyc.pop_front()));
                end
            end else begin
                assert (!(exp_cyc.size() != 0 && exp_cyc[0] <= cyc)) else begin
                    $display("Missing rvalid for a load due at %0t", $time);
                    n_errors++;
                    void'(exp_data.pop_front());
                    void'(exp_cyc.pop_front());
                end
            end
            if (err) begin
                assert (err_cyc.size() != 0 && err_cyc[0] == cyc) else begin
                    $display("Unexpected err pulse at %0t", $time);
                    n_errors++;
                end
                if (err_cyc.size() != 0) begin
                    void'(err_cyc.pop_front());
                end
            end else begin
                assert (!(err_cyc.size() != 0 && err_cyc[0] <= cyc)) else begin
                    $display("Missing err pulse for a misaligned request at %0t", $time);
                    n_errors++;
                    void'(err_cyc.pop_front());
                end
            end
        end
    end

    initial begin
        word_t      r;
        word_t      d;
        logic [7:0] wa;
        rst_n    = 1'b0;
        req      = 1'b0;
        wr       = 1'b0;
        size     = size_byte;
        sign_ext = 1'b0;
        addr     = '0;
        wdata    = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Outputs quiet after reset then preload and word reads
        check_word("rvalid after reset", word_t'(rvalid), '0);
        check_word("err after reset", word_t'(err), '0);
        check_word("rdata after reset", rdata, '0);
        for (int w = 0; w < 256; w++) begin
            issue_request(1'b1, size_word, 1'b0, {w[7:0], 2'b00}, $random(seed));
        end
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            issue_request(1'b0, size_word, 1'b0, {r[7:0], 2'b00}, '0);
        end
        wait_drain();
        end_test("reset and preload");

        for (int i = 0; i < 60; i++) begin
            r = $random(seed);
            d = $random(seed);
            issue_request(1'b1, r[10] ? size_half : size_byte, 1'b0,
                          {r[9:1], r[0] & !r[10]}, d);
            issue_request(1'b0, size_word, 1'b0, {r[9:2], 2'b00}, '0);
        end
        wait_drain();
        end_test("sub-word stores");

        // Words with all lane sign bits set or all clear
        for (int i = 0; i < 16; i++) begin
            r  = $random(seed);
            wa = r[7:0];
            d  = $random(seed);
            d  = i[0] ? (d | 32'h80808080) : (d & 32'h7f7f7f7f);
            issue_request(1'b1, size_word, 1'b0, {wa, 2'b00}, d);
            for (int o = 0; o < 4; o++) begin
                issue_request(1'b0, size_byte, 1'b0, {wa, o[1:0]}, '0);
                issue_request(1'b0, size_byte, 1'b1, {wa, o[1:0]}, '0);
                if (o[0] == 1'b0) begin
                    issue_request(1'b0, size_half, 1'b0, {wa, o[1:0]}, '0);
                    issue_request(1'b0, size_half, 1'b1, {wa, o[1:0]}, '0);
                end
            end
        end
        wait_drain();
        end_test("sub-word loads");

        for (int i = 0; i < 8; i++) begin
            r  = $random(seed);
            wa = r[7:0];
            for (int o = 1; o < 4; o++) begin
                issue_request(1'b1, size_word, 1'b0, {wa, o[1:0]}, $random(seed));
                issue_request(1'b0, size_word, 1'b1, {wa, o[1:0]}, '0);
                if (o != 2) begin
                    issue_request(1'b1, size_half, 1'b0, {wa, o[1:0]}, $random(seed));
                    issue_request(1'b0, size_half, 1'b1, {wa, o[1:0]}, '0);
                end
            end
            issue_request(1'b0, size_word, 1'b0, {wa, 2'b00}, '0);
        end
        wait_drain();
        end_test("misaligned requests");

        for (int i = 0; i < 20; i++) begin
            r = $random(seed);
            issue_request(1'b1, size_word, 1'b0, {r[7:0], 2'b00}, $random(seed));
            issue_request(1'b0, size_word, 1'b0, {r[7:0], 2'b00}, '0);
            issue_request(1'b1, size_byte, 1'b0, r[17:8], $random(seed));
            issue_request(1'b0, size_byte, r[18], r[17:8], '0);
        end
        for (int i = 0; i < 400; i++) begin
            r = $random(seed);
            if (r[31:30] == 2'b00) begin
                idle_cycle();
            end else begin
                issue_request(r[0], (r[2:1] == 2'b11) ? size_word : access_size_e'(r[2:1]),
                              r[3], r[13:4], $random(seed));
            end
        end
        wait_drain();
        end_test("back-to-back traffic");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 n_tests, n_failed, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule : tb_mem_subsys

`default_nettype wire

/* src.f */
common/mem_geom_pkg.sv
common/access_pkg.sv
design/lane_encoder.sv
sram_bank/sram_byte_enable.sv
design/load_align.sv
design/mem_subsys_top.sv
verification/tb_mem_subsys.sv

/* Makefile */
# Verilator build and run for the data memory testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
RTL_TOP   ?= mem_subsys_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	elif ! grep -q "sim passed" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
